/* source/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int INST_WIDTH      = 32;
    localparam int REG_WIDTH       = 5;
    localparam int IMEM_DEPTH      = 64;
    localparam int IMEM_ADDR_WIDTH = 6;
    localparam int FETCH_CNT_WIDTH = IMEM_ADDR_WIDTH + 1;  // Needs to hold a full 64 word run
    localparam int QUEUE_DEPTH     = 4;

    // RV32I major opcodes, instruction bits 6 to 0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYS    = 7'b1110011;

    // The NONE encodings sit at zero so a cleared record decodes as a bubble
    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_RS1_RS2,
        SRC_RS1_IMM,
        SRC_PC_IMM,
        SRC_PC_FOUR   // Link value for jal and jalr
    } src_sel_t;

    typedef enum logic [3:0] {
        LSU_NONE,
        LSU_LB,
        LSU_LH,
        LSU_LW,
        LSU_LBU,
        LSU_LHU,
        LSU_SB,
        LSU_SH,
        LSU_SW
    } lsu_op_t;

    typedef struct packed {
        logic [INST_WIDTH-1:0] pc;
        logic [INST_WIDTH-1:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic [INST_WIDTH-1:0] pc;
        logic [REG_WIDTH-1:0]  rd;
        logic                  rd_wen;
        logic [REG_WIDTH-1:0]  rs1;
        logic [REG_WIDTH-1:0]  rs2;
        logic [INST_WIDTH-1:0] imm;
        alu_op_t               alu_op;
        src_sel_t              src_sel;
        lsu_op_t               lsu_op;
        logic [2:0]            funct3;
        logic                  branch;
        logic                  jal;
        logic                  jalr;
    } decoded_t;

endpackage

/* source/inst_fetch.sv */
module inst_fetch
    import rv_decode_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       imem_we,
    input  logic [IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [INST_WIDTH-1:0]      imem_wdata,

    input  logic                       start,
    input  logic [IMEM_ADDR_WIDTH-1:0] fetch_base,
    input  logic [FETCH_CNT_WIDTH-1:0] fetch_count,
    output logic                       busy,

    input  logic                       full,
    output logic                       push,
    output fetch_entry_t               push_entry
);

    logic [INST_WIDTH-1:0]      imem [IMEM_DEPTH];
    logic [IMEM_ADDR_WIDTH-1:0] fetch_addr;
    logic [FETCH_CNT_WIDTH-1:0] remaining;

    // Loader port, one word per cycle
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign busy = (remaining != '0);
    assign push = busy && !full;  // Stalls in place while the queue is full

    // Asynchronous read so the word goes out in the same cycle as push
    assign push_entry.inst = imem[fetch_addr];
    assign push_entry.pc   = {{(INST_WIDTH - IMEM_ADDR_WIDTH - 2){1'b0}}, fetch_addr, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_addr <= '0;
            remaining  <= '0;
        end else if (start) begin
            fetch_addr <= fetch_base;
            remaining  <= fetch_count;
        end else if (push) begin
            fetch_addr <= fetch_addr + 1'b1;  // Wraps at the top of memory
            remaining  <= remaining - 1'b1;
        end
    end

endmodule

/* source/inst_queue.sv */
module inst_queue #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,

    input  logic   push,
    input  entry_t push_entry,
    output logic   full,

    input  logic   pop,
    output logic   empty,
    output entry_t head
);

    entry_t                         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]       wr_ptr;
    logic [$clog2(DEPTH)-1:0]       rd_ptr;
    logic [$clog2(DEPTH + 1)-1:0]   count;
    logic                           do_push;
    logic                           do_pop;

    assign full  = (int'(count) == DEPTH);
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];  // First word falls through

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (int'(wr_ptr) == DEPTH - 1) wr_ptr <= '0;
                else wr_ptr <= wr_ptr + 1'b1;
            end

            if (do_pop) begin
                if (int'(rd_ptr) == DEPTH - 1) rd_ptr <= '0;
                else rd_ptr <= rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leaves the occupancy as it is
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* source/imm_gen.sv */
module imm_gen
    import rv_decode_pkg::*;
(
    input  logic [INST_WIDTH-1:0] inst,
    output logic [INST_WIDTH-1:0] imm
);

    logic [6:0]            opcode;
    logic                  sign;
    logic [INST_WIDTH-1:0] imm_i;
    logic [INST_WIDTH-1:0] imm_s;
    logic [INST_WIDTH-1:0] imm_b;
    logic [INST_WIDTH-1:0] imm_u;
    logic [INST_WIDTH-1:0] imm_j;

    assign opcode = inst[6:0];
    assign sign   = inst[31];

    assign imm_i = {{(INST_WIDTH - 12){sign}}, inst[31:20]};
    assign imm_s = {{(INST_WIDTH - 12){sign}}, inst[31:25], inst[11:7]};

    // B and J keep bit 0 clear since targets are halfword aligned
    assign imm_b = {{(INST_WIDTH - 13){sign}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign imm_j = {{(INST_WIDTH - 21){sign}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM,
            OPC_SYS:    imm = imm_i;
            OPC_STORE:  imm = imm_s;
            OPC_BRANCH: imm = imm_b;
            OPC_LUI,
            OPC_AUIPC:  imm = imm_u;
            OPC_JAL:    imm = imm_j;
            default:    imm = '0;
        endcase
    end

endmodule

/* source/op_decode.sv */
module op_decode
    import rv_decode_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_t    alu_op,
    output src_sel_t   src_sel,
    output lsu_op_t    lsu_op
);

    // Shared funct3 table for OP and OP_IMM
    function automatic alu_op_t arith_op(
        input logic [2:0] f3,
        input logic       sub_en,
        input logic       sra_en
    );
        alu_op_t op;
        case (f3)
            3'd0:    op = sub_en ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = sra_en ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    logic alt;

    assign alt = funct7[5];  // Selects SUB and SRA

    always_comb begin
        case (opcode)
            OPC_OP:     alu_op = arith_op(funct3, alt, alt);
            OPC_OP_IMM: alu_op = arith_op(funct3, 1'b0, alt);  // No SUBI in RV32I
            OPC_LUI:    alu_op = ALU_LUI;
            OPC_AUIPC,
            OPC_LOAD,
            OPC_STORE,
            OPC_JAL,
            OPC_JALR:   alu_op = ALU_ADD;
            OPC_BRANCH: alu_op = ALU_SUB;
            default:    alu_op = ALU_NONE;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_OP,
            OPC_BRANCH: src_sel = SRC_RS1_RS2;
            OPC_OP_IMM,
            OPC_LOAD,
            OPC_STORE:  src_sel = SRC_RS1_IMM;
            OPC_AUIPC:  src_sel = SRC_PC_IMM;
            OPC_JAL,
            OPC_JALR:   src_sel = SRC_PC_FOUR;
            default:    src_sel = SRC_RS1_RS2;
        endcase
    end

    always_comb begin
        lsu_op = LSU_NONE;
        if (opcode == OPC_LOAD) begin
            case (funct3)
                3'd0:    lsu_op = LSU_LB;
                3'd1:    lsu_op = LSU_LH;
                3'd2:    lsu_op = LSU_LW;
                3'd4:    lsu_op = LSU_LBU;
                3'd5:    lsu_op = LSU_LHU;
                default: lsu_op = LSU_NONE;
            endcase
        end else if (opcode == OPC_STORE) begin
            case (funct3)
                3'd0:    lsu_op = LSU_SB;
                3'd1:    lsu_op = LSU_SH;
                3'd2:    lsu_op = LSU_SW;
                default: lsu_op = LSU_NONE;
            endcase
        end
    end

endmodule

/* source/inst_decode.sv */
module inst_decode
    import rv_decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         hold,

    input  logic         empty,
    input  fetch_entry_t head,
    output logic         pop,

    output logic         out_valid,
    output decoded_t     result
);

    logic [INST_WIDTH-1:0] inst;
    logic [6:0]            opcode;
    logic [REG_WIDTH-1:0]  rd_fld;
    logic [REG_WIDTH-1:0]  rs1_fld;
    logic [REG_WIDTH-1:0]  rs2_fld;
    logic [REG_WIDTH-1:0]  rd;
    logic                  rd_wen;
    logic [REG_WIDTH-1:0]  rs1;
    logic [REG_WIDTH-1:0]  rs2;
    logic [INST_WIDTH-1:0] imm;
    alu_op_t               alu_op;
    src_sel_t              src_sel;
    lsu_op_t               lsu_op;
    decoded_t              dec;

    assign inst    = head.inst;
    assign opcode  = inst[6:0];
    assign rd_fld  = inst[11:7];
    assign rs1_fld = inst[19:15];
    assign rs2_fld = inst[24:20];

    assign pop = !empty && !hold;

    // Which register fields are live for each opcode
    always_comb begin
        case (opcode)
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL:    {rs1, rs2, rd, rd_wen} = {{REG_WIDTH{1'b0}}, {REG_WIDTH{1'b0}}, rd_fld, 1'b1};
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM,
            OPC_SYS:    {rs1, rs2, rd, rd_wen} = {rs1_fld, {REG_WIDTH{1'b0}}, rd_fld, 1'b1};
            OPC_BRANCH,
            OPC_STORE:  {rs1, rs2, rd, rd_wen} = {rs1_fld, rs2_fld, {REG_WIDTH{1'b0}}, 1'b0};
            OPC_OP:     {rs1, rs2, rd, rd_wen} = {rs1_fld, rs2_fld, rd_fld, 1'b1};
            default:    {rs1, rs2, rd, rd_wen} = '0;  // FENCE lands here as well
        endcase
    end

    imm_gen imm_gen_inst (
        .inst (inst),
        .imm  (imm)
    );

    op_decode op_decode_inst (
        .opcode  (opcode),
        .funct3  (inst[14:12]),
        .funct7  (inst[31:25]),
        .alu_op  (alu_op),
        .src_sel (src_sel),
        .lsu_op  (lsu_op)
    );

    always_comb begin
        dec.pc      = head.pc;
        dec.rd      = rd;
        dec.rd_wen  = rd_wen;
        dec.rs1     = rs1;
        dec.rs2     = rs2;
        dec.imm     = imm;
        dec.alu_op  = alu_op;
        dec.src_sel = src_sel;
        dec.lsu_op  = lsu_op;
        dec.funct3  = inst[14:12];
        dec.branch  = (opcode == OPC_BRANCH);
        dec.jal     = (opcode == OPC_JAL);
        dec.jalr    = (opcode == OPC_JALR);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= pop;  // One pulse per popped word
            if (pop) begin
                result <= dec;
            end
        end
    end

endmodule

/* source/decode_top.sv */
module decode_top
    import rv_decode_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       imem_we,
    input  logic [IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [INST_WIDTH-1:0]      imem_wdata,

    input  logic                       start,
    input  logic [IMEM_ADDR_WIDTH-1:0] fetch_base,
    input  logic [FETCH_CNT_WIDTH-1:0] fetch_count,
    output logic                       busy,

    input  logic                       hold,

    output logic                       out_valid,
    output logic [INST_WIDTH-1:0]      out_pc,
    output logic [REG_WIDTH-1:0]       rd,
    output logic                       rd_wen,
    output logic [REG_WIDTH-1:0]       rs1,
    output logic [REG_WIDTH-1:0]       rs2,
    output logic [INST_WIDTH-1:0]      imm,
    output alu_op_t                    alu_op,
    output src_sel_t                   src_sel,
    output lsu_op_t                    lsu_op,
    output logic [2:0]                 funct3,
    output logic                       branch,
    output logic                       jal,
    output logic                       jalr
);

    logic         push;
    logic         full;
    logic         pop;
    logic         empty;
    fetch_entry_t push_entry;
    fetch_entry_t head;
    decoded_t     result;

    inst_fetch inst_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .start       (start),
        .fetch_base  (fetch_base),
        .fetch_count (fetch_count),
        .busy        (busy),
        .full        (full),
        .push        (push),
        .push_entry  (push_entry)
    );

    inst_queue #(
        .entry_t (fetch_entry_t),
        .DEPTH   (QUEUE_DEPTH)
    ) inst_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .full       (full),
        .pop        (pop),
        .empty      (empty),
        .head       (head)
    );

    inst_decode inst_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .hold      (hold),
        .empty     (empty),
        .head      (head),
        .pop       (pop),
        .out_valid (out_valid),
        .result    (result)
    );

    assign out_pc  = result.pc;
    assign rd      = result.rd;
    assign rd_wen  = result.rd_wen;
    assign rs1     = result.rs1;
    assign rs2     = result.rs2;
    assign imm     = result.imm;
    assign alu_op  = result.alu_op;
    assign src_sel = result.src_sel;
    assign lsu_op  = result.lsu_op;
    assign funct3  = result.funct3;
    assign branch  = result.branch;
    assign jal     = result.jal;
    assign jalr    = result.jalr;

endmodule

/* testbench/tb_decode_top.sv */
module tb_decode_top
    import rv_decode_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RUN_A_COUNT = 64;
    localparam int RUN_B_COUNT = 64;
    localparam int RUN_C_COUNT = 40;
    localparam int WATCHDOG_CYCLES = 8 + 70 + (RUN_A_COUNT * 10 + 200)
                                   + (RUN_B_COUNT * 10 + 200) + (RUN_C_COUNT * 10 + 200);

    logic                       clk;
    logic                       rst;
    logic                       imem_we;
    logic [IMEM_ADDR_WIDTH-1:0] imem_addr;
    logic [INST_WIDTH-1:0]      imem_wdata;
    logic                       start;
    logic [IMEM_ADDR_WIDTH-1:0] fetch_base;
    logic [FETCH_CNT_WIDTH-1:0] fetch_count;
    logic                       busy;
    logic                       hold;
    logic                       out_valid;
    logic [INST_WIDTH-1:0]      out_pc;
    logic [REG_WIDTH-1:0]       rd;
    logic                       rd_wen;
    logic [REG_WIDTH-1:0]       rs1;
    logic [REG_WIDTH-1:0]       rs2;
    logic [INST_WIDTH-1:0]      imm;
    alu_op_t                    alu_op;
    src_sel_t                   src_sel;
    lsu_op_t                    lsu_op;
    logic [2:0]                 funct3;
    logic                       branch;
    logic                       jal;
    logic                       jalr;

    logic [INST_WIDTH-1:0] prog [IMEM_DEPTH];
    logic [6:0]            valid_opc [11] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                                              OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
                                              OPC_FENCE, OPC_SYS};
    fetch_entry_t          expected_q [$];  // Words still owed by the DUT with the oldest first
    decoded_t              exp_rec = '0;
    integer                seed;
    int                    run_count = 0;
    int                    received = 0;
    bit                    running = 0;
    int                    check_errors = 0;
    int                    other_errors = 0;

    decode_top decode_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] make_word(
        input logic [6:0] f7,
        input logic [4:0] r2,
        input logic [4:0] r1,
        input logic [2:0] f3,
        input logic [4:0] rdest,
        input logic [6:0] opc
    );
        return {f7, r2, r1, f3, rdest, opc};
    endfunction

    // Expected decode of one queue entry built from the RV32I field rules
    function automatic decoded_t ref_decode(input fetch_entry_t e);
        decoded_t    d;
        logic [31:0] w;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        has_rd;
        logic        has_rs1;
        logic        has_rs2;
        w = e.inst;
        opc = w[6:0];
        f3 = w[14:12];
        has_rd = opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM,
                             OPC_OP, OPC_SYS};
        has_rs1 = opc inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP,
                              OPC_SYS};
        has_rs2 = opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};
        d = '0;
        d.pc = e.pc;
        d.rd = has_rd ? w[11:7] : 5'd0;
        d.rd_wen = has_rd;
        d.rs1 = has_rs1 ? w[19:15] : 5'd0;
        d.rs2 = has_rs2 ? w[24:20] : 5'd0;
        d.funct3 = f3;
        d.branch = (opc == OPC_BRANCH);
        d.jal = (opc == OPC_JAL);
        d.jalr = (opc == OPC_JALR);
        case (opc)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYS: d.imm = 32'($signed(w[31:20]));
            OPC_STORE:  d.imm = 32'($signed({w[31:25], w[11:7]}));
            OPC_BRANCH: d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            OPC_LUI, OPC_AUIPC: d.imm = {w[31:12], 12'h000};
            OPC_JAL:    d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default:    d.imm = '0;
        endcase
        case (opc)
            OPC_LUI: d.alu_op = ALU_LUI;
            OPC_AUIPC, OPC_LOAD, OPC_STORE, OPC_JAL, OPC_JALR: d.alu_op = ALU_ADD;
            OPC_BRANCH: d.alu_op = ALU_SUB;  // Compare by subtraction
            OPC_OP, OPC_OP_IMM: begin
                case (f3)
                    3'd0: d.alu_op = (opc == OPC_OP && w[30]) ? ALU_SUB : ALU_ADD;
                    3'd1: d.alu_op = ALU_SLL;
                    3'd2: d.alu_op = ALU_SLT;
                    3'd3: d.alu_op = ALU_SLTU;
                    3'd4: d.alu_op = ALU_XOR;
                    3'd5: d.alu_op = w[30] ? ALU_SRA : ALU_SRL;
                    3'd6: d.alu_op = ALU_OR;
                    3'd7: d.alu_op = ALU_AND;
                endcase
            end
            default: d.alu_op = ALU_NONE;
        endcase
        if (opc inside {OPC_OP_IMM, OPC_LOAD, OPC_STORE}) d.src_sel = SRC_RS1_IMM;
        else if (opc == OPC_AUIPC) d.src_sel = SRC_PC_IMM;
        else if (opc inside {OPC_JAL, OPC_JALR}) d.src_sel = SRC_PC_FOUR;
        else d.src_sel = SRC_RS1_RS2;
        case ({opc, f3})
            {OPC_LOAD, 3'd0}:  d.lsu_op = LSU_LB;
            {OPC_LOAD, 3'd1}:  d.lsu_op = LSU_LH;
            {OPC_LOAD, 3'd2}:  d.lsu_op = LSU_LW;
            {OPC_LOAD, 3'd4}:  d.lsu_op = LSU_LBU;
            {OPC_LOAD, 3'd5}:  d.lsu_op = LSU_LHU;
            {OPC_STORE, 3'd0}: d.lsu_op = LSU_SB;
            {OPC_STORE, 3'd1}: d.lsu_op = LSU_SH;
            {OPC_STORE, 3'd2}: d.lsu_op = LSU_SW;
            default:           d.lsu_op = LSU_NONE;
        endcase
        return d;
    endfunction

    task automatic report_mismatch(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Every funct3 of OP, OP_IMM, BRANCH, LOAD and STORE with both immediate signs
    task automatic build_program();
        for (int f = 0; f < 8; f++) begin
            prog[f * 5] = make_word(7'h00, 5'(f + 2), 5'(f + 1), 3'(f), 5'(f + 8), OPC_OP);
            prog[f * 5 + 1] = make_word(f[0] ? 7'h7f : 7'h01, 5'(f * 3), 5'(f + 4), 3'(f),
                                        5'(31 - f), OPC_OP_IMM);
            prog[f * 5 + 2] = make_word(f[0] ? 7'h7e : 7'h02, 5'(f + 5), 5'(f + 6), 3'(f),
                                        f[1] ? 5'h1f : 5'h08, OPC_BRANCH);
            prog[f * 5 + 3] = make_word(f[1] ? 7'h40 : 7'h05, 5'(f + 7), 5'(f + 10), 3'(f),
                                        5'(f + 12), OPC_LOAD);
            prog[f * 5 + 4] = make_word(f[2] ? 7'h7e : 7'h03, 5'(f + 14), 5'(f + 3), 3'(f),
                                        5'(f + 17), OPC_STORE);
        end
        prog[40] = make_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP);      // sub
        prog[41] = make_word(7'h20, 5'd4, 5'd5, 3'd5, 5'd6, OPC_OP);      // sra
        prog[42] = make_word(7'h00, 5'd7, 5'd8, 3'd5, 5'd9, OPC_OP_IMM);  // srli
        prog[43] = make_word(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, OPC_OP_IMM);  // addi stays add
        prog[44] = make_word(7'h09, 5'h11, 5'h0a, 3'd3, 5'd5, OPC_LUI);
        prog[45] = make_word(7'h7f, 5'h1f, 5'h1f, 3'd7, 5'd1, OPC_LUI);
        prog[46] = make_word(7'h40, 5'h00, 5'h00, 3'd0, 5'd3, OPC_AUIPC);
        prog[47] = make_word(7'h12, 5'h05, 5'h1c, 3'd2, 5'd4, OPC_AUIPC);
        prog[48] = make_word(7'h00, 5'h08, 5'h00, 3'd0, 5'd1, OPC_JAL);
        prog[49] = make_word(7'h7f, 5'h1d, 5'h1f, 3'd7, 5'd0, OPC_JAL);
        prog[50] = make_word(7'h7f, 5'h18, 5'd2, 3'd0, 5'd1, OPC_JALR);
        prog[51] = make_word(7'h01, 5'h04, 5'd6, 3'd0, 5'd0, OPC_JALR);
        prog[52] = make_word(7'h0f, 5'h0f, 5'd0, 3'd0, 5'd0, OPC_FENCE);
        prog[53] = make_word(7'h00, 5'd1, 5'd0, 3'd0, 5'd0, OPC_SYS);
        prog[54] = make_word(7'h55, 5'h0a, 5'h15, 3'd0, 5'h1b, 7'b1111111);  // Not an RV32I opcode
        for (int i = 55; i < IMEM_DEPTH; i++) begin
            prog[i] = $random(seed);
            prog[i][6:0] = valid_opc[{$random(seed)} % 11];
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            imem_we = 1'b1;
            imem_addr = IMEM_ADDR_WIDTH'(i);
            imem_wdata = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
    endtask

    task automatic run_program(
        input logic [IMEM_ADDR_WIDTH-1:0] base,
        input logic [FETCH_CNT_WIDTH-1:0] count,
        input logic                       use_hold
    );
        fetch_entry_t e;
        int           hold_left;
        int           free_left;
        bit           done;
        hold_left = 0;
        free_left = 0;
        @(negedge clk);
        start = 1'b1;
        fetch_base = base;
        fetch_count = count;
        for (int i = 0; i < int'(count); i++) begin
            e.pc = 32'(((int'(base) + i) % IMEM_DEPTH) * 4);  // Fetch wraps at the top
            e.inst = prog[(int'(base) + i) % IMEM_DEPTH];
            expected_q.push_back(e);
        end
        run_count = int'(count);
        received = 0;
        @(negedge clk);
        start = 1'b0;
        running = 1'b1;
        do begin
            @(posedge clk);
            done = (received == run_count);
            @(negedge clk);
            if (use_hold && !done) begin
                // Hold stretches outlast the queue depth so fetch has to stall
                if (hold_left > 0) begin
                    hold = 1'b1;
                    hold_left--;
                end else if (free_left > 0) begin
                    hold = 1'b0;
                    free_left--;
                end else begin
                    hold_left = QUEUE_DEPTH + 1 + ({$random(seed)} % 8);
                    free_left = 1 + ({$random(seed)} % 4);
                    hold = 1'b1;
                end
            end
        end while (!done);
        hold = 1'b0;
        running = 1'b0;
        repeat (6) @(negedge clk);  // Room for a stray extra result to show up
        assert (!busy) else report_mismatch("fetch still busy after the run");
    endtask

    // Expected record changes only on the falling edge
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (expected_q.size() == 0) begin
                other_errors++;
                $display("Extra decoded result at %0t with no instruction pending", $time);
            end else begin
                exp_rec = ref_decode(expected_q.pop_front());
                received++;
            end
        end
        if (running && received + QUEUE_DEPTH < run_count) begin
            assert (busy) else report_mismatch("busy low while words remain to fetch");
        end
    end

    assert property (@(posedge clk) disable iff (rst) out_valid |-> out_pc == exp_rec.pc)
        else report_mismatch($sformatf("pc got %h expected %h", $sampled(out_pc), exp_rec.pc));
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> {rd, rd_wen, rs1, rs2}
                      == {exp_rec.rd, exp_rec.rd_wen, exp_rec.rs1, exp_rec.rs2})
        else report_mismatch($sformatf("register fields wrong at pc %h", exp_rec.pc));
    assert property (@(posedge clk) disable iff (rst) out_valid |-> imm == exp_rec.imm)
        else report_mismatch($sformatf("imm got %h expected %h", $sampled(imm), exp_rec.imm));
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> {branch, jal, jalr} == {exp_rec.branch, exp_rec.jal, exp_rec.jalr})
        else report_mismatch($sformatf("control flags wrong at pc %h", exp_rec.pc));
    assert property (@(posedge clk) disable iff (rst)
        out_valid |-> alu_op == exp_rec.alu_op && src_sel == exp_rec.src_sel
                      && lsu_op == exp_rec.lsu_op && funct3 == exp_rec.funct3)
        else report_mismatch($sformatf("operation fields wrong at pc %h", exp_rec.pc));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the pipeline stopped delivering results",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst = 1'b1;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        start = 1'b0;
        fetch_base = '0;
        fetch_count = '0;
        hold = 1'b0;
        seed = 28363;
        build_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!busy && !out_valid && out_pc == '0 && rd == '0 && !rd_wen && rs1 == '0
                && rs2 == '0 && imm == '0 && alu_op == ALU_NONE && src_sel == SRC_RS1_RS2
                && lsu_op == LSU_NONE && funct3 == '0 && !branch && !jal && !jalr)
            else report_mismatch("outputs not cleared by reset");
        load_program();
        run_program(IMEM_ADDR_WIDTH'(0), FETCH_CNT_WIDTH'(RUN_A_COUNT), 1'b0);
        run_program(IMEM_ADDR_WIDTH'(0), FETCH_CNT_WIDTH'(RUN_B_COUNT), 1'b1);
        run_program(IMEM_ADDR_WIDTH'(37), FETCH_CNT_WIDTH'(RUN_C_COUNT), 1'b1);  // Wraps past 63
        $display("Errors: %0d value mismatches, %0d unexpected results",
                 check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
source/rv_decode_pkg.sv
source/inst_fetch.sv
source/inst_queue.sv
source/imm_gen.sv
source/op_decode.sv
source/inst_decode.sv
source/decode_top.sv
testbench/tb_decode_top.sv
